// ==== filelist.f ====
+incdir+rtl
rtl/ctrlPkg.sv
rtl/instrDecoder.sv
rtl/stepSequencer.sv
rtl/controlWordGen.sv
rtl/controlUnit.sv
verif/tbClock.sv
verif/controlUnit_properties.sv
verif/tbControlUnit.sv

// ==== Makefile ====
# Verilator simulation of the control unit testbench

VERILATOR ?= verilator
TOP ?= tbControlUnit
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
ERROR_LIMIT ?= 1000
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard rtl/*.sv rtl/*.svh verif/*.sv)
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG ERROR_LIMIT VFLAGS"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) +verilator+error+limit+$(ERROR_LIMIT) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
		echo "Result: FAIL, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "Testbench passed" $(LOG); then \
		echo "Result: no verdict in $(LOG)"; \
		exit 1; \
	fi
	@echo "Result: PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/tbControlUnit.sv ====
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module tbControlUnit;

	localparam int DRIVE_DELAY = 2;
	localparam int STEP_TIMEOUT = 100; // Longest instruction is a shift by 63
	localparam int RESET_TIMEOUT = 40;

	logic CLK;
	logic reset;
	ctrlPkg::instr_t instruction;
	logic zFlag;
	logic nFlag;
	logic instrRegEn;
	logic pcEn;
	ctrlPkg::sel_t pcMuxSel;
	ctrlPkg::sel_t aSel;
	ctrlPkg::sel_t bSel;
	logic immTypeSel;
	logic loadA;
	logic rfWriteEn;
	logic shiftLeft;
	logic shiftRight;
	logic arithShift;
	ctrlPkg::aluOp_t aluOp;

	integer seed = 32'hdc13;
	int errors = 0;
	int timeouts = 0;
	ctrlPkg::instr_t curWord = '0;
	logic [3:0] progOp[$];
	logic [5:0] progLow[$]; // Funct for R-type, shift amount for shifts
	logic progZ[$];
	logic progN[$];

	tbClock u_tbClock
	(
		.CLK(CLK),
		.reset(reset)
	);

	controlUnit u_controlUnit
	(
		.CLK(CLK),
		.reset(reset),
		.instruction(instruction),
		.zFlag(zFlag),
		.nFlag(nFlag),
		.instrRegEn(instrRegEn),
		.pcEn(pcEn),
		.pcMuxSel(pcMuxSel),
		.aSel(aSel),
		.bSel(bSel),
		.immTypeSel(immTypeSel),
		.loadA(loadA),
		.rfWriteEn(rfWriteEn),
		.shiftLeft(shiftLeft),
		.shiftRight(shiftRight),
		.arithShift(arithShift),
		.aluOp(aluOp)
	);

	function automatic logic [6:0] enableWord();
		return {instrRegEn, pcEn, rfWriteEn, loadA, shiftLeft, shiftRight, arithShift};
	endfunction

	task automatic checkVal(input string name, input int got, input int exp);
		assert (got == exp)
		else
		begin
			errors++;
			$display("FAILED %s: got %0h, expected %0h, instruction %h", name, got, exp, curWord);
		end
	endtask

	task automatic addInstr(input logic [3:0] op, input logic [5:0] low, input logic z,
		input logic n);
		progOp.push_back(op);
		progLow.push_back(low);
		progZ.push_back(z);
		progN.push_back(n);
	endtask

	task automatic buildProgram();
		logic [31:0] r;
		logic [3:0] shiftOp;
		logic [3:0] memOps[7] = '{4'h3, 4'h7, 4'h8, 4'h9, 4'hA, 4'hB, 4'hC};
		for (int f = 0; f < 8; f++)
			if (f != `FUNCT_SLT && f != `FUNCT_MUL)
				addInstr(`OP_RTYPE, 6'(f), 1'b0, 1'b0);
		addInstr(`OP_ADDI, 6'd0, 1'b0, 1'b0);
		addInstr(`OP_ANDI, 6'd0, 1'b0, 1'b0);
		addInstr(`OP_RTYPE, 6'(`FUNCT_SLT), 1'b0, 1'b0);
		addInstr(`OP_RTYPE, 6'(`FUNCT_SLT), 1'b0, 1'b1);
		addInstr(`OP_SLL, 6'd0, 1'b0, 1'b0);
		addInstr(`OP_SRL, 6'd63, 1'b0, 1'b0);
		addInstr(`OP_SRA, 6'd63, 1'b0, 1'b0);
		addInstr(`OP_SRA, 6'd0, 1'b0, 1'b0);
		addInstr(`OP_SLL, 6'd63, 1'b0, 1'b0);
		for (int i = 0; i < 6; i++)
		begin
			r = $random(seed);
			shiftOp = (r[1:0] == 2'd0) ? `OP_SLL : (r[1:0] == 2'd1) ? `OP_SRL : `OP_SRA;
			addInstr(shiftOp, r[13:8], r[16], r[17]);
		end
		addInstr(`OP_BREQ, 6'd0, 1'b0, 1'b0);
		addInstr(`OP_BREQ, 6'd0, 1'b1, 1'b0);
		addInstr(`OP_BRNE, 6'd0, 1'b0, 1'b0);
		addInstr(`OP_BRNE, 6'd0, 1'b1, 1'b0);
		addInstr(`OP_JUMP, 6'd0, 1'b0, 1'b0);
		addInstr(`OP_RTYPE, 6'(`FUNCT_MUL), 1'b0, 1'b0);
		foreach (memOps[i])
			addInstr(memOps[i], 6'd0, 1'b0, 1'b0);
	endtask

	task automatic checkReset();
		int cycles;
		cycles = 0;
		do
		begin
			@(negedge CLK);
			cycles++;
			checkVal("enables {instrRegEn..arithShift} in reset", enableWord(), 0);
		end
		while (reset && cycles < RESET_TIMEOUT);
		if (reset)
		begin
			timeouts++;
			$display("Timeout: reset still high after %0d cycles", RESET_TIMEOUT);
		end
		else
		begin
			@(negedge CLK); // Second cycle after reset falls
			checkVal("instrRegEn after reset", instrRegEn, 1);
		end
	endtask

	// Runs one instruction from its fetch to the next fetch
	task automatic execute(input logic [3:0] op, input logic [5:0] low, input logic z,
		input logic n);
		int k;
		int expLen;
		int expRfAt;
		int expPcAt;
		int expShift;
		logic [1:0] expPcSel;
		logic [2:0] expAlu;
		bit isAlu;
		bit isBranch;
		bit done;
		int rfCnt;
		int rfAt;
		int pcCnt;
		int pcAt;
		int loadCnt;
		int immCnt;
		int immLast;
		int leftCnt;
		int rightCnt;
		int arithCnt;
		int firstShift;
		int lastShift;
		logic [1:0] pcSelAt;
		logic [1:0] aSelAt2;
		logic [1:0] bSelAt2;
		logic [2:0] aluAtWrite;
		curWord = {op, 12'($random(seed))};
		if (op == `OP_RTYPE)
			curWord[2:0] = low[2:0];
		else if (op == `OP_SLL || op == `OP_SRL || op == `OP_SRA)
			curWord[5:0] = low;
		expLen = 2; // NOP unless listed below
		expRfAt = 0;
		expPcAt = 0;
		expShift = 0;
		expPcSel = `PC_INC;
		expAlu = `ALU_ADD;
		isAlu = 1'b0;
		isBranch = (op == `OP_BREQ || op == `OP_BRNE);
		case (op)
			`OP_RTYPE:
			begin
				if (low[2:0] != `FUNCT_MUL)
				begin
					expLen = 4;
					expRfAt = 3;
					isAlu = (low[2:0] != `FUNCT_SLT);
					expAlu = low[2:0];
				end
			end
			`OP_ADDI, `OP_ANDI:
			begin
				expLen = 4;
				expRfAt = 3;
				isAlu = 1'b1;
				expAlu = (op == `OP_ADDI) ? `ALU_ADD : `ALU_AND;
			end
			`OP_SLL, `OP_SRL, `OP_SRA:
			begin
				expLen = low + 3;
				expRfAt = low + 2;
				expShift = low;
			end
			`OP_BREQ, `OP_BRNE:
			begin
				expLen = 6;
				if ((op == `OP_BREQ) == z) // Taken
				begin
					expPcAt = 4;
					expPcSel = `PC_BRANCH;
				end
			end
			`OP_JUMP:
			begin
				expLen = 4;
				expPcAt = 2;
				expPcSel = `PC_JUMP;
			end
			default:
				expLen = 2;
		endcase

		@(posedge CLK);
		#DRIVE_DELAY;
		instruction = curWord;
		zFlag = z;
		nFlag = n;
		k = 0;
		done = 1'b0;
		rfCnt = 0;
		rfAt = 0;
		pcCnt = 0;
		pcAt = 0;
		loadCnt = 0;
		immCnt = 0;
		immLast = 0;
		leftCnt = 0;
		rightCnt = 0;
		arithCnt = 0;
		firstShift = 0;
		lastShift = 0;
		pcSelAt = '0;
		aSelAt2 = '0;
		bSelAt2 = '0;
		aluAtWrite = '0;
		while (!done && k < STEP_TIMEOUT)
		begin
			@(negedge CLK);
			k++;
			if (instrRegEn)
				done = 1'b1;
			else
			begin
				if (rfWriteEn)
				begin
					rfCnt++;
					rfAt = k;
					aluAtWrite = aluOp;
				end
				if (pcEn)
				begin
					pcCnt++;
					pcAt = k;
					pcSelAt = pcMuxSel;
				end
				if (immTypeSel)
				begin
					immCnt++;
					immLast = k;
				end
				if (shiftLeft || shiftRight)
				begin
					if (firstShift == 0)
						firstShift = k;
					lastShift = k;
				end
				if (loadA)
					loadCnt++;
				if (shiftLeft)
					leftCnt++;
				if (shiftRight)
					rightCnt++;
				if (arithShift)
					arithCnt++;
				if (k == 2)
				begin
					aSelAt2 = aSel;
					bSelAt2 = bSel;
				end
			end
		end

		if (!done)
		begin
			timeouts++;
			$display("Timeout: no fetch within %0d cycles after instruction %h", STEP_TIMEOUT,
				curWord);
		end
		else
		begin
			checkVal("instrRegEn offset of next fetch", k, expLen);
			checkVal("rfWriteEn pulse count", rfCnt, (expRfAt != 0) ? 1 : 0);
			if (expRfAt != 0)
				checkVal("rfWriteEn offset", rfAt, expRfAt);
			if (isAlu)
				checkVal("aluOp at rfWriteEn", aluAtWrite, expAlu);
			checkVal("pcEn pulse count", pcCnt, (expPcAt != 0) ? 1 : 0);
			if (expPcAt != 0)
			begin
				checkVal("pcEn offset", pcAt, expPcAt);
				checkVal("pcMuxSel at pcEn", pcSelAt, expPcSel);
			end
			checkVal("immTypeSel cycles", immCnt, isBranch ? 2 : 0);
			if (isBranch)
				checkVal("immTypeSel last offset", immLast, 2);
			checkVal("shiftLeft cycles", leftCnt, (op == `OP_SLL) ? expShift : 0);
			checkVal("shiftRight cycles", rightCnt,
				(op == `OP_SRL || op == `OP_SRA) ? expShift : 0);
			checkVal("arithShift cycles", arithCnt, (op == `OP_SRA) ? expShift : 0);
			if (expShift != 0)
			begin
				checkVal("first shift strobe offset", firstShift, 2);
				checkVal("shift strobe span", lastShift - firstShift + 1, expShift);
			end
			if (op == `OP_RTYPE && low[2:0] == `FUNCT_SLT)
			begin
				checkVal("aSel in EXEC2", aSelAt2, `SEL_REG);
				checkVal("bSel in EXEC2", bSelAt2, n ? `SEL_ALT : `SEL_REG);
			end
			if (expLen == 2)
				checkVal("loadA cycles", loadCnt, 0);
		end
	endtask

	task automatic finishRun();
		int propFails;
		propFails = u_controlUnit.u_properties.assertFails;
		$display("Check errors: %0d, timeouts: %0d, property errors: %0d", errors, timeouts,
			propFails);
		if (errors == 0 && timeouts == 0 && propFails == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	endtask

	initial
	begin
		instruction = '0;
		zFlag = 1'b0;
		nFlag = 1'b0;
		buildProgram();
		checkReset();
		for (int i = 0; i < progOp.size() && timeouts == 0; i++)
			execute(progOp[i], progLow[i], progZ[i], progN[i]);
		finishRun();
	end

endmodule

// ==== verif/controlUnit_properties.sv ====
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module controlUnit_properties
(
	input logic CLK,
	input logic reset,
	input ctrlPkg::seqState_t state,
	input ctrlPkg::instClass_t instClass,
	input ctrlPkg::shamt_t shamt,
	input logic instrRegEn,
	input logic pcEn,
	input ctrlPkg::sel_t pcMuxSel,
	input logic loadA,
	input logic rfWriteEn,
	input logic shiftLeft,
	input logic shiftRight,
	input logic arithShift
);

	int assertFails = 0; // Read by the testbench at the end
	logic anyEnable;

	assign anyEnable = instrRegEn || pcEn || loadA || rfWriteEn || shiftLeft || shiftRight
		|| arithShift;

	resetIdle: assert property (@(posedge CLK) reset |=> state == ctrlPkg::IDLE && !anyEnable)
	else
	begin
		assertFails++;
		$error("Sequencer left IDLE or raised an enable during reset");
	end

	fetchThenExec: assert property (@(posedge CLK) disable iff (reset)
		state == ctrlPkg::FETCH |=> state == ctrlPkg::EXEC1)
	else
	begin
		assertFails++;
		$error("FETCH not followed by EXEC1");
	end

	// Register write is always the last step
	writeThenFetch: assert property (@(posedge CLK) disable iff (reset)
		rfWriteEn |=> instrRegEn)
	else
	begin
		assertFails++;
		$error("rfWriteEn not followed by a fetch");
	end

	// Shifting ends with the register write
	shiftThenWrite: assert property (@(posedge CLK) disable iff (reset)
		$fell(shiftLeft || shiftRight) |-> rfWriteEn)
	else
	begin
		assertFails++;
		$error("Shift strobe not followed by rfWriteEn");
	end

	fetchWord: assert property (@(posedge CLK) disable iff (reset)
		instrRegEn |-> pcEn && pcMuxSel == `PC_INC)
	else
	begin
		assertFails++;
		$error("Fetch without pcEn and PC_INC");
	end

	zeroShift: assert property (@(posedge CLK) disable iff (reset)
		state == ctrlPkg::EXEC1 && instClass == `CLASS_SHIFT && shamt == '0
		|=> state == ctrlPkg::SHIFTDONE)
	else
	begin
		assertFails++;
		$error("Shift by zero did not go straight to SHIFTDONE");
	end

	branchTail: assert property (@(posedge CLK) disable iff (reset)
		state == ctrlPkg::EXEC5 |=> instrRegEn)
	else
	begin
		assertFails++;
		$error("EXEC5 not followed by a fetch");
	end

endmodule

bind controlUnit controlUnit_properties u_properties (.*);

// ==== verif/tbClock.sv ====
`timescale 1ns/1ps

module tbClock
(
	output logic CLK,
	output logic reset
);

	localparam int HALF_PERIOD = 20; // 40 ns clock
	localparam int RESET_CYCLES = 16;
	localparam int DRIVE_DELAY = 2;

	initial
	begin
		CLK = 1'b0;
		forever
			#HALF_PERIOD CLK = ~CLK;
	end

	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge CLK);
		#DRIVE_DELAY;
		reset = 1'b0;
	end

endmodule

// ==== rtl/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit
(
	input logic CLK,
	input logic reset,
	input ctrlPkg::instr_t instruction,
	input logic zFlag,
	input logic nFlag,
	output logic instrRegEn,
	output logic pcEn,
	output ctrlPkg::sel_t pcMuxSel,
	output ctrlPkg::sel_t aSel,
	output ctrlPkg::sel_t bSel,
	output logic immTypeSel,
	output logic loadA,
	output logic rfWriteEn,
	output logic shiftLeft,
	output logic shiftRight,
	output logic arithShift,
	output ctrlPkg::aluOp_t aluOp
);

	ctrlPkg::instClass_t instClass;
	ctrlPkg::aluOp_t aluFunct;
	ctrlPkg::shamt_t shamt;
	ctrlPkg::seqState_t state;

	instrDecoder u_instrDecoder
	(
		.instruction(instruction),
		.instClass(instClass),
		.aluFunct(aluFunct),
		.shamt(shamt)
	);

	stepSequencer u_stepSequencer
	(
		.CLK(CLK),
		.reset(reset),
		.instClass(instClass),
		.shamt(shamt),
		.state(state)
	);

	controlWordGen u_controlWordGen
	(
		.CLK(CLK),
		.reset(reset),
		.state(state),
		.instClass(instClass),
		.aluFunct(aluFunct),
		.instruction(instruction),
		.zFlag(zFlag),
		.nFlag(nFlag),
		.instrRegEn(instrRegEn),
		.pcEn(pcEn),
		.pcMuxSel(pcMuxSel),
		.aSel(aSel),
		.bSel(bSel),
		.immTypeSel(immTypeSel),
		.loadA(loadA),
		.rfWriteEn(rfWriteEn),
		.shiftLeft(shiftLeft),
		.shiftRight(shiftRight),
		.arithShift(arithShift),
		.aluOp(aluOp)
	);

endmodule

// ==== rtl/controlWordGen.sv ====
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module controlWordGen
(
	input logic CLK,
	input logic reset,
	input ctrlPkg::seqState_t state,
	input ctrlPkg::instClass_t instClass,
	input ctrlPkg::aluOp_t aluFunct,
	input ctrlPkg::instr_t instruction,
	input logic zFlag,
	input logic nFlag,
	output logic instrRegEn,
	output logic pcEn,
	output ctrlPkg::sel_t pcMuxSel,
	output ctrlPkg::sel_t aSel,
	output ctrlPkg::sel_t bSel,
	output logic immTypeSel,
	output logic loadA,
	output logic rfWriteEn,
	output logic shiftLeft,
	output logic shiftRight,
	output logic arithShift,
	output ctrlPkg::aluOp_t aluOp
);

	logic [`OPCODE_W-1:0] opcode;
	logic immOperand;
	logic branchTaken;
	logic shifting;

	assign opcode = instruction[`INSTR_W-1 -: `OPCODE_W];
	assign immOperand = (opcode == `OP_ADDI) || (opcode == `OP_ANDI);
	assign shifting = (state == ctrlPkg::SHIFTING);

	assign shiftLeft = shifting && (opcode == `OP_SLL);
	assign shiftRight = shifting && (opcode == `OP_SRL || opcode == `OP_SRA);
	assign arithShift = shifting && (opcode == `OP_SRA);

	always_ff @(posedge CLK)
	begin
		if (reset)
			branchTaken <= 1'b0;
		else if (state == ctrlPkg::EXEC3 && instClass == `CLASS_BRANCH)
			branchTaken <= (opcode == `OP_BRNE) ? !zFlag : zFlag; // Compare result from EXEC2
	end

	always_comb
	begin
		instrRegEn = 1'b0;
		pcEn = 1'b0;
		pcMuxSel = `PC_INC;
		aSel = `SEL_RF;
		bSel = `SEL_RF;
		immTypeSel = 1'b0;
		loadA = 1'b0;
		rfWriteEn = 1'b0;
		aluOp = `ALU_ADD;
		if (state == ctrlPkg::FETCH)
		begin
			instrRegEn = 1'b1;
			pcEn = 1'b1;
		end
		else
		begin
			case (instClass)
				`CLASS_ALU:
				begin
					aluOp = aluFunct;
					bSel = immOperand ? `SEL_IMM : `SEL_RF;
					loadA = (state == ctrlPkg::EXEC1) || (state == ctrlPkg::EXEC2);
					rfWriteEn = (state == ctrlPkg::EXEC3);
				end
				`CLASS_SLT:
				begin
					aluOp = `ALU_SUB; // Sets nFlag in EXEC1
					if (state == ctrlPkg::EXEC2)
					begin
						loadA = 1'b1;
						aSel = `SEL_REG;
						bSel = nFlag ? `SEL_ALT : `SEL_REG;
						aluOp = nFlag ? aluFunct : `ALU_SUB;
					end
					rfWriteEn = (state == ctrlPkg::EXEC3);
				end
				`CLASS_SHIFT:
				begin
					bSel = `SEL_REG;
					loadA = (state == ctrlPkg::EXEC1);
					rfWriteEn = (state == ctrlPkg::SHIFTDONE);
				end
				`CLASS_BRANCH:
				begin
					aluOp = `ALU_SUB;
					immTypeSel = (state == ctrlPkg::EXEC1) || (state == ctrlPkg::EXEC2);
					if (state == ctrlPkg::EXEC3)
					begin
						// Branch target into A while the flag is latched
						aSel = `SEL_ALT;
						bSel = `SEL_IMM;
						aluOp = `ALU_ADD;
						loadA = 1'b1;
					end
					if (state == ctrlPkg::EXEC4)
					begin
						pcEn = branchTaken;
						pcMuxSel = branchTaken ? `PC_BRANCH : `PC_INC;
					end
				end
				`CLASS_JUMP:
				begin
					bSel = `SEL_IMM;
					if (state == ctrlPkg::EXEC2)
					begin
						pcEn = 1'b1;
						pcMuxSel = `PC_JUMP;
					end
				end
				default:
					aluOp = `ALU_ADD; // NOP, no enables
			endcase
		end
	end

endmodule

// ==== rtl/stepSequencer.sv ====
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module stepSequencer
(
	input logic CLK,
	input logic reset,
	input ctrlPkg::instClass_t instClass,
	input ctrlPkg::shamt_t shamt,
	output ctrlPkg::seqState_t state
);

	ctrlPkg::seqState_t nextState;
	ctrlPkg::shamt_t shiftCnt;

	always_ff @(posedge CLK)
	begin
		if (reset)
			state <= ctrlPkg::IDLE;
		else
			state <= nextState;
	end

	// Shift countdown, loaded with the amount in EXEC1
	always_ff @(posedge CLK)
	begin
		if (reset)
			shiftCnt <= '0;
		else if (state == ctrlPkg::EXEC1 && instClass == `CLASS_SHIFT)
			shiftCnt <= shamt;
		else if (state == ctrlPkg::SHIFTING)
			shiftCnt <= shiftCnt - 1'b1;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			ctrlPkg::IDLE:
				nextState = ctrlPkg::FETCH;
			ctrlPkg::FETCH:
				nextState = ctrlPkg::EXEC1;
			ctrlPkg::EXEC1:
			begin
				if (instClass == `CLASS_NOP)
					nextState = ctrlPkg::FETCH;
				else if (instClass == `CLASS_SHIFT)
					nextState = (shamt == '0) ? ctrlPkg::SHIFTDONE : ctrlPkg::SHIFTING;
				else
					nextState = ctrlPkg::EXEC2;
			end
			ctrlPkg::EXEC2:
				nextState = ctrlPkg::EXEC3;
			ctrlPkg::EXEC3:
			begin
				if (instClass == `CLASS_BRANCH)
					nextState = ctrlPkg::EXEC4;
				else
					nextState = ctrlPkg::FETCH; // ALU, SLT and JUMP end here
			end
			ctrlPkg::EXEC4:
				nextState = ctrlPkg::EXEC5;
			ctrlPkg::EXEC5:
				nextState = ctrlPkg::FETCH;
			ctrlPkg::SHIFTING:
			begin
				if (shiftCnt == 'd1) // Last shift cycle
					nextState = ctrlPkg::SHIFTDONE;
			end
			ctrlPkg::SHIFTDONE:
				nextState = ctrlPkg::FETCH;
			default:
				nextState = ctrlPkg::IDLE;
		endcase
	end

endmodule

// ==== rtl/instrDecoder.sv ====
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module instrDecoder
(
	input ctrlPkg::instr_t instruction,
	output ctrlPkg::instClass_t instClass,
	output ctrlPkg::aluOp_t aluFunct,
	output ctrlPkg::shamt_t shamt
);

	logic [`OPCODE_W-1:0] opcode;
	logic [`FUNCT_W-1:0] funct;

	assign opcode = instruction[`INSTR_W-1 -: `OPCODE_W];
	assign funct = instruction[`FUNCT_W-1:0];
	assign shamt = instruction[`SHAMT_W-1:0];

	always_comb
	begin
		instClass = `CLASS_NOP; // Memory and unknown opcodes
		aluFunct = `ALU_ADD;
		case (opcode)
			`OP_RTYPE:
			begin
				aluFunct = funct;
				if (funct == `FUNCT_SLT)
					instClass = `CLASS_SLT;
				else if (funct != `FUNCT_MUL)
					instClass = `CLASS_ALU;
			end
			`OP_ADDI:
			begin
				instClass = `CLASS_ALU;
				aluFunct = `ALU_ADD;
			end
			`OP_ANDI:
			begin
				instClass = `CLASS_ALU;
				aluFunct = `ALU_AND;
			end
			`OP_SLL, `OP_SRL, `OP_SRA:
				instClass = `CLASS_SHIFT;
			`OP_BREQ, `OP_BRNE:
			begin
				instClass = `CLASS_BRANCH;
				aluFunct = `ALU_SUB; // Compare by subtraction
			end
			`OP_JUMP:
				instClass = `CLASS_JUMP;
			default:
				instClass = `CLASS_NOP;
		endcase
	end

endmodule

// ==== rtl/ctrlPkg.sv ====
`include "ctrl_defines.svh"

package ctrlPkg;

	typedef logic [`INSTR_W-1:0] instr_t;
	typedef logic [`FUNCT_W-1:0] aluOp_t; // Same encoding as the funct field
	typedef logic [`SHAMT_W-1:0] shamt_t;
	typedef logic [`SEL_W-1:0] sel_t;
	typedef logic [`CLASS_W-1:0] instClass_t;

	typedef enum logic [3:0]
	{
		IDLE,
		FETCH,
		EXEC1,
		EXEC2,
		EXEC3,
		EXEC4,
		EXEC5,
		SHIFTING,
		SHIFTDONE
	} seqState_t;

endpackage

// ==== rtl/ctrl_defines.svh ====
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

`define INSTR_W 16
`define OPCODE_W 4
`define FUNCT_W 3
`define SHAMT_W 6
`define SEL_W 2
`define CLASS_W 3

`define OP_RTYPE 4'b0000
`define OP_ADDI 4'b0001
`define OP_ANDI 4'b0010
`define OP_SLL 4'b0100
`define OP_SRL 4'b0101
`define OP_SRA 4'b0110
`define OP_BREQ 4'b1101
`define OP_BRNE 4'b1110
`define OP_JUMP 4'b1111

`define FUNCT_SLT 3'b101
`define FUNCT_MUL 3'b010 // Runs as a no-operation

`define ALU_ADD 3'b000
`define ALU_SUB 3'b001
`define ALU_AND 3'b100

`define SEL_REG 2'b00 // Datapath result register
`define SEL_ALT 2'b01
`define SEL_RF 2'b10
`define SEL_IMM 2'b11

`define PC_INC 2'b00
`define PC_JUMP 2'b01
`define PC_BRANCH 2'b10

`define CLASS_ALU 3'd0
`define CLASS_SLT 3'd1
`define CLASS_SHIFT 3'd2
`define CLASS_BRANCH 3'd3
`define CLASS_JUMP 3'd4
`define CLASS_NOP 3'd5

`endif
